// ==== bench/scoreboard_ctrl_assertions.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module scoreboard_ctrl_assertions (
    input logic           clk,
    input logic           rst,
    input logic           issue_en,
    input logic           record_en,
    input sb_pkg::fu_id_t dec_fu,
    input logic           alu_en,
    input logic           mem_en,
    input logic           mul_en,
    input logic           div_en,
    input logic           jump_en,
    input logic           jump_done,
    input logic           is_jump,
    input logic           reg_write
);
    import sb_pkg::*;

    int         fail_count = 0;
    logic [4:0] enables;

    assign enables = {jump_en, alu_en, mem_en, mul_en, div_en};

    // quiet outputs while held in reset
    a_reset_idle: assert property (@(posedge clk)
        rst |-> (enables == '0) && !reg_write && issue_en)
        else begin
            fail_count++;
            $error("unit enables or reg_write active, or issue_en low, during reset");
        end

    // each dispatch strobe lasts a single cycle
    a_en_pulse: assert property (@(posedge clk) disable iff (rst)
        (enables != '0) |=> ((enables & $past(enables)) == '0))
        else begin
            fail_count++;
            $error("a unit enable stayed high for two cycles in a row");
        end

    // a recorded jump closes the issue window
    a_jump_hold: assert property (@(posedge clk) disable iff (rst)
        (record_en && dec_fu == `SB_FU_JUMP) |=> !issue_en)
        else begin
            fail_count++;
            $error("issue_en high right after a jump was recorded");
        end

    a_flush: assert property (@(posedge clk) disable iff (rst)
        (jump_done && is_jump && !issue_en) |=> (issue_en && !record_en))
        else begin
            fail_count++;
            $error("taken jump did not give one discarding issue cycle");
        end

endmodule

// ==== bench/scoreboard_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module scoreboard_ctrl_tb;
    import sb_pkg::*;

    localparam int MAX_CYCLES = 600;   // about three times the directed run

    logic                clk;
    logic                rst;
    inst_word_t          inst;
    logic [`SB_NUM_FU:1] done_q = '0;   // indexed by unit code
    logic                is_jump = 1'b0;
    logic                issue_en;
    logic                alu_en;
    logic                mem_en;
    logic                mul_en;
    logic                div_en;
    logic                jump_en;
    op_code_t            disp_op;
    reg_idx_t            rs1_ctrl;
    reg_idx_t            rs2_ctrl;
    logic                reg_write;
    fu_id_t              write_sel;
    reg_idx_t            rd_ctrl;

    logic [`SB_NUM_FU:1] en_vec;
    int                  unit_timer [1:`SB_NUM_FU];
    logic [31:0]         lfsr_state = 32'h809f;
    logic                take_branch = 1'b0;
    int                  errors = 0;
    int                  cycle_count = 0;
    int                  issued = 0;
    int                  retired = 0;
    logic                watch_raw = 1'b0;
    logic                div_wb_seen = 1'b0;
    logic                mul_en_seen = 1'b0;

    scoreboard_ctrl u_scoreboard_ctrl (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .alu_done  (done_q[`SB_FU_ALU]),
        .mem_done  (done_q[`SB_FU_MEM]),
        .mul_done  (done_q[`SB_FU_MUL]),
        .div_done  (done_q[`SB_FU_DIV]),
        .jump_done (done_q[`SB_FU_JUMP]),
        .is_jump   (is_jump),
        .issue_en  (issue_en),
        .alu_en    (alu_en),
        .mem_en    (mem_en),
        .mul_en    (mul_en),
        .div_en    (div_en),
        .jump_en   (jump_en),
        .disp_op   (disp_op),
        .rs1_ctrl  (rs1_ctrl),
        .rs2_ctrl  (rs2_ctrl),
        .reg_write (reg_write),
        .write_sel (write_sel),
        .rd_ctrl   (rd_ctrl)
    );

    bind scoreboard_ctrl scoreboard_ctrl_assertions u_sva (
        .clk       (clk),
        .rst       (rst),
        .issue_en  (issue_en),
        .record_en (record_en),
        .dec_fu    (dec_fu),
        .alu_en    (alu_en),
        .mem_en    (mem_en),
        .mul_en    (mul_en),
        .div_en    (div_en),
        .jump_en   (jump_en),
        .jump_done (jump_done),
        .is_jump   (is_jump),
        .reg_write (reg_write)
    );

    function automatic inst_word_t encode_r(input logic [6:0] f7, input reg_idx_t rs2,
                                            input reg_idx_t rs1, input logic [2:0] f3,
                                            input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, `SB_OPC_OP};
    endfunction

    function automatic inst_word_t encode_i(input logic [11:0] imm, input reg_idx_t rs1,
                                            input reg_idx_t rd);
        return {imm, rs1, 3'b000, rd, `SB_OPC_OP_IMM};   // addi
    endfunction

    function automatic inst_word_t encode_b(input reg_idx_t rs2, input reg_idx_t rs1);
        return {7'b0, rs2, rs1, 3'b000, 5'b0, `SB_OPC_BRANCH};   // beq, offset 0
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int next_delay();
        logic [1:0] bits;
        lfsr_state = lfsr_step(lfsr_state);
        bits[0] = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        bits[1] = lfsr_state[0];
        return 1 + int'(bits);
    endfunction

    task automatic verify(input logic ok, input string msg);
        assert (ok) else begin
            errors++;
            $display("[ERROR] %0t ns: %s", $time, msg);
        end
    endtask

    // hold the word until the DUT takes it
    task automatic issue(input inst_word_t word);
        inst <= word;
        @(posedge clk);
        while (!issue_en) begin
            @(posedge clk);
        end
        issued++;
        inst <= '0;
    endtask

    task automatic issue_blocked(input inst_word_t word, input fu_id_t blocker);
        logic prev_wb;
        prev_wb = 1'b0;
        inst <= word;
        @(posedge clk);
        verify(!issue_en, "issue_en high although the instruction should stall");
        while (!issue_en) begin
            prev_wb = reg_write && (write_sel == blocker);
            @(posedge clk);
        end
        verify(prev_wb, "stall released without the blocking unit writing back");
        issued++;
        inst <= '0;
    endtask

    task automatic drain;
        while (retired != issued) begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic report_and_finish;
        int sva_fails;
        sva_fails = u_scoreboard_ctrl.u_sva.fail_count;
        $display("errors: %0d from checks, %0d from assertions", errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign en_vec = {jump_en, div_en, mul_en, mem_en, alu_en};

    // unit model, one done pulse 1..4 cycles after each enable
    always @(posedge clk) begin
        is_jump <= take_branch && (unit_timer[`SB_FU_JUMP] == 1);
        for (int u = 1; u <= `SB_NUM_FU; u++) begin
            done_q[u] <= (unit_timer[u] == 1);
            if (unit_timer[u] > 0) unit_timer[u]--;
            if (en_vec[u]) unit_timer[u] = next_delay();
        end
    end

    always @(posedge clk) begin
        if (reg_write) retired <= retired + 1;
        if (watch_raw) begin
            if (mul_en) begin
                verify(div_wb_seen, "mul_en rose before the divide wrote x5");
                verify(disp_op == `SB_OP_MUL && rs1_ctrl == 5'd5 && rs2_ctrl == 5'd6,
                       "multiply dispatched with wrong operation or source registers");
            end
            if (reg_write && rd_ctrl == 5'd6) begin
                verify(mul_en_seen, "x6 written back before the multiply read it");
            end
            if (reg_write && write_sel == `SB_FU_DIV) div_wb_seen = 1'b1;
            if (mul_en) mul_en_seen = 1'b1;
        end
        verify(!(reg_write && rd_ctrl == 5'd13), "flushed instruction wrote back");
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d from checks, %0d from assertions before the timeout",
                     errors, u_scoreboard_ctrl.u_sva.fail_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        inst = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        verify(en_vec == '0 && !reg_write, "enable or reg_write active after reset");
        verify(issue_en, "issue_en low after reset");

        // addi x3, x1, 5 on an idle core
        issue(encode_i(12'd5, 5'd1, 5'd3));
        @(posedge clk);
        verify(alu_en, "alu_en not high two edges after the addi");
        verify(disp_op == `SB_OP_ADDI, "wrong dispatched operation code for addi");
        verify(rs1_ctrl == 5'd1, "rs1_ctrl differs from the addi source");
        @(posedge clk);
        verify(!alu_en, "alu_en longer than one cycle");
        do @(posedge clk); while (!done_q[`SB_FU_ALU]);
        @(posedge clk);
        verify(reg_write && write_sel == `SB_FU_ALU && rd_ctrl == 5'd3,
               "addi result not written the cycle after alu_done");
        drain();

        // structural stall, then waw stall on x12
        issue(encode_i(12'd7, 5'd0, 5'd10));
        issue_blocked(encode_r(`SB_F7_BASE, 5'd2, 5'd1, 3'b000, 5'd11), `SB_FU_ALU);
        drain();
        issue(encode_r(`SB_F7_MULDIV, 5'd2, 5'd1, 3'b000, 5'd12));
        issue_blocked(encode_i(12'd1, 5'd0, 5'd12), `SB_FU_MUL);
        drain();

        // div x5, then mul x7 <- x5, x6, then addi x6
        watch_raw = 1'b1;
        issue(encode_r(`SB_F7_MULDIV, 5'd2, 5'd1, 3'b100, 5'd5));
        issue(encode_r(`SB_F7_MULDIV, 5'd6, 5'd5, 3'b000, 5'd7));
        issue(encode_i(12'd9, 5'd0, 5'd6));
        drain();
        verify(div_wb_seen && mul_en_seen, "raw sequence never reached the multiply");

        // taken beq, the word shown in the flush cycle is dropped
        take_branch = 1'b1;
        issue(encode_b(5'd2, 5'd1));
        begin
            logic prev_jd;
            prev_jd = 1'b0;
            inst <= encode_i(12'd3, 5'd0, 5'd13);
            @(posedge clk);
            verify(!issue_en, "issue_en high while the branch was pending");
            while (!issue_en) begin
                prev_jd = done_q[`SB_FU_JUMP];
                @(posedge clk);
            end
            verify(prev_jd, "issue resumed without jump_done");
            inst <= '0;
        end
        repeat (8) begin
            @(posedge clk);
            verify(!alu_en, "flushed instruction was dispatched");
        end
        drain();
        repeat (4) @(posedge clk);
        report_and_finish();
    end

endmodule

// ==== logic/fu_status_table.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module fu_status_table (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             record_en,
    input  sb_pkg::fu_id_t                   dec_fu,
    input  sb_pkg::op_code_t                 dec_op,
    input  sb_pkg::reg_idx_t                 dec_dst,
    input  sb_pkg::reg_idx_t                 dec_src1,
    input  sb_pkg::reg_idx_t                 dec_src2,
    input  sb_pkg::fu_id_t                   src1_fu,
    input  sb_pkg::fu_id_t                   src2_fu,
    input  logic                             alu_done,
    input  logic                             mem_done,
    input  logic                             mul_done,
    input  logic                             div_done,
    input  logic                             jump_done,
    input  sb_pkg::fu_id_t                   wb_fu,
    output logic [`SB_NUM_FU:1]              busy,
    output sb_pkg::reg_idx_t [`SB_NUM_FU:1]  entry_src1,
    output sb_pkg::reg_idx_t [`SB_NUM_FU:1]  entry_src2,
    output logic [`SB_NUM_FU:1]              entry_rdy1,
    output logic [`SB_NUM_FU:1]              entry_rdy2,
    output sb_pkg::reg_idx_t [`SB_NUM_FU:1]  entry_dst,
    output logic [`SB_NUM_FU:1]              entry_done,
    output logic                             alu_en,
    output logic                             mem_en,
    output logic                             mul_en,
    output logic                             div_en,
    output logic                             jump_en,
    output sb_pkg::op_code_t                 disp_op,
    output sb_pkg::reg_idx_t                 rs1_ctrl,
    output sb_pkg::reg_idx_t                 rs2_ctrl
);
    import sb_pkg::*;

    op_code_t [`SB_NUM_FU:1] entry_op;
    fu_id_t   [`SB_NUM_FU:1] wait_fu1;   // producer the operand still waits on
    fu_id_t   [`SB_NUM_FU:1] wait_fu2;
    logic     [`SB_NUM_FU:1] done_in;
    logic                    rdy1_now;
    logic                    rdy2_now;
    fu_id_t                  disp_fu;

    assign done_in = {jump_done, div_done, mul_done, mem_done, alu_done};

    // a producer retiring on this same edge counts as already written
    assign rdy1_now = (src1_fu == `SB_FU_NONE) || (src1_fu == wb_fu);
    assign rdy2_now = (src2_fu == `SB_FU_NONE) || (src2_fu == wb_fu);

    // jump first, then alu..div in code order
    always_comb begin
        disp_fu = `SB_FU_NONE;
        for (int i = `SB_NUM_FU - 1; i >= 1; i--) begin
            if (entry_rdy1[i] && entry_rdy2[i]) begin
                disp_fu = fu_id_t'(i);
            end
        end
        if (entry_rdy1[`SB_FU_JUMP] && entry_rdy2[`SB_FU_JUMP]) begin
            disp_fu = `SB_FU_JUMP;
        end
    end

    assign alu_en   = (disp_fu == `SB_FU_ALU);
    assign mem_en   = (disp_fu == `SB_FU_MEM);
    assign mul_en   = (disp_fu == `SB_FU_MUL);
    assign div_en   = (disp_fu == `SB_FU_DIV);
    assign jump_en  = (disp_fu == `SB_FU_JUMP);
    assign disp_op  = (disp_fu == `SB_FU_NONE) ? '0 : entry_op[disp_fu];
    assign rs1_ctrl = (disp_fu == `SB_FU_NONE) ? '0 : entry_src1[disp_fu];
    assign rs2_ctrl = (disp_fu == `SB_FU_NONE) ? '0 : entry_src2[disp_fu];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= '0;
            entry_rdy1 <= '0;
            entry_rdy2 <= '0;
            entry_done <= '0;
            wait_fu1   <= '0;
            wait_fu2   <= '0;
        end else begin
            if (record_en) begin
                busy[dec_fu]       <= 1'b1;
                entry_rdy1[dec_fu] <= rdy1_now;
                entry_rdy2[dec_fu] <= rdy2_now;
                wait_fu1[dec_fu]   <= rdy1_now ? `SB_FU_NONE : src1_fu;
                wait_fu2[dec_fu]   <= rdy2_now ? `SB_FU_NONE : src2_fu;
            end
            if (disp_fu != `SB_FU_NONE) begin
                entry_rdy1[disp_fu] <= 1'b0;   // operands read
                entry_rdy2[disp_fu] <= 1'b0;
            end
            entry_done <= entry_done | (done_in & busy);
            if (wb_fu != `SB_FU_NONE) begin
                busy[wb_fu]       <= 1'b0;
                entry_done[wb_fu] <= 1'b0;
                // raw wake-up
                for (int i = 1; i <= `SB_NUM_FU; i++) begin
                    if (wait_fu1[i] == wb_fu) begin
                        entry_rdy1[i] <= 1'b1;
                        wait_fu1[i]   <= `SB_FU_NONE;
                    end
                    if (wait_fu2[i] == wb_fu) begin
                        entry_rdy2[i] <= 1'b1;
                        wait_fu2[i]   <= `SB_FU_NONE;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (record_en) begin
            entry_op[dec_fu]   <= dec_op;
            entry_dst[dec_fu]  <= dec_dst;
            entry_src1[dec_fu] <= dec_src1;
            entry_src2[dec_fu] <= dec_src2;
        end
    end

endmodule

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module inst_decoder (
    input  sb_pkg::inst_word_t inst,
    output sb_pkg::fu_id_t     dec_fu,
    output sb_pkg::op_code_t   dec_op,
    output sb_pkg::reg_idx_t   dec_dst,
    output sb_pkg::reg_idx_t   dec_src1,
    output sb_pkg::reg_idx_t   dec_src2
);
    import sb_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd_field;
    reg_idx_t   rs1_field;
    reg_idx_t   rs2_field;
    logic       alt_ok;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7    = inst[31:25];
    assign rd_field  = inst[11:7];
    assign rs1_field = inst[19:15];
    assign rs2_field = inst[24:20];

    // funct7 0x20 only legal on sub and sra
    assign alt_ok = (funct7 == `SB_F7_BASE) ||
                    (funct7 == `SB_F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        dec_fu  = `SB_FU_NONE;
        dec_op  = '0;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            `SB_OPC_OP: begin
                if (funct7 == `SB_F7_MULDIV) begin
                    dec_fu = funct3[2] ? `SB_FU_DIV : `SB_FU_MUL;
                    dec_op = (funct3[2] ? `SB_OP_DIV : `SB_OP_MUL) | {3'b000, funct3[1:0]};
                end else if (alt_ok) begin
                    dec_fu = `SB_FU_ALU;
                    dec_op = `SB_OP_ADD | {1'b0, funct7[5], funct3};
                end
                use_rd  = (dec_fu != `SB_FU_NONE);
                use_rs1 = (dec_fu != `SB_FU_NONE);
                use_rs2 = (dec_fu != `SB_FU_NONE);
            end
            `SB_OPC_OP_IMM: begin
                // only shifts carry funct7 in the immediate
                if (funct3[1:0] != 2'b01 || alt_ok) begin
                    dec_fu  = `SB_FU_ALU;
                    dec_op  = `SB_OP_ADDI | {1'b0, funct3 == 3'b101 && funct7[5], funct3};
                    use_rd  = 1'b1;
                    use_rs1 = 1'b1;
                end
            end
            `SB_OPC_LOAD: begin
                if (funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                    dec_fu  = `SB_FU_MEM;
                    dec_op  = `SB_OP_LOAD | {2'b00, funct3};
                    use_rd  = 1'b1;
                    use_rs1 = 1'b1;
                end
            end
            `SB_OPC_STORE: begin
                if (funct3 inside {3'd0, 3'd1, 3'd2}) begin
                    dec_fu  = `SB_FU_MEM;
                    dec_op  = `SB_OP_STORE | {2'b00, funct3};
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            `SB_OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin
                    dec_fu  = `SB_FU_JUMP;
                    dec_op  = `SB_OP_BEQ | {2'b00, funct3};
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            `SB_OPC_LUI: begin
                dec_fu = `SB_FU_ALU;
                dec_op = `SB_OP_LUI;
                use_rd = 1'b1;
            end
            `SB_OPC_AUIPC: begin
                dec_fu = `SB_FU_ALU;
                dec_op = `SB_OP_AUIPC;
                use_rd = 1'b1;
            end
            `SB_OPC_JAL: begin
                dec_fu = `SB_FU_JUMP;
                dec_op = `SB_OP_JAL;
                use_rd = 1'b1;
            end
            `SB_OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    dec_fu  = `SB_FU_JUMP;
                    dec_op  = `SB_OP_JALR;
                    use_rd  = 1'b1;
                    use_rs1 = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // unused fields read as x0
    assign dec_dst  = use_rd ? rd_field : '0;
    assign dec_src1 = use_rs1 ? rs1_field : '0;
    assign dec_src2 = use_rs2 ? rs2_field : '0;

endmodule

// ==== logic/issue_control.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module issue_control (
    input  logic                clk,
    input  logic                rst,
    input  sb_pkg::fu_id_t      dec_fu,
    input  logic [`SB_NUM_FU:1] busy,
    input  logic                dst_pending,
    input  logic                jump_done,
    input  logic                is_jump,
    output logic                issue_en,
    output logic                record_en
);
    import sb_pkg::*;

    ctrl_state_t state;
    logic        busy_hit;
    logic        stall;

    assign busy_hit = (dec_fu != `SB_FU_NONE) && busy[dec_fu];   // structural
    assign stall    = busy_hit || dst_pending;

    // flush cycle lets the fetched word go by without recording it
    assign issue_en  = (state == CTRL_FLUSH) || (state == CTRL_RUN && !stall);
    assign record_en = (state == CTRL_RUN) && !stall && (dec_fu != `SB_FU_NONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= CTRL_RUN;
        end else begin
            case (state)
                CTRL_RUN: begin
                    if (record_en && dec_fu == `SB_FU_JUMP) begin
                        state <= CTRL_WAIT_JUMP;
                    end
                end
                CTRL_WAIT_JUMP: begin
                    if (jump_done) begin
                        state <= is_jump ? CTRL_FLUSH : CTRL_RUN;   // taken -> drop one
                    end
                end
                default: state <= CTRL_RUN;
            endcase
        end
    end

endmodule

// ==== logic/reg_result_status.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module reg_result_status (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            record_en,
    input  sb_pkg::fu_id_t                  dec_fu,
    input  sb_pkg::reg_idx_t                dec_dst,
    input  sb_pkg::reg_idx_t                dec_src1,
    input  sb_pkg::reg_idx_t                dec_src2,
    input  sb_pkg::fu_id_t                  wb_fu,
    input  sb_pkg::reg_idx_t [`SB_NUM_FU:1] entry_dst,
    output sb_pkg::fu_id_t                  src1_fu,
    output sb_pkg::fu_id_t                  src2_fu,
    output logic                            dst_pending
);
    import sb_pkg::*;

    fu_id_t rrs [0:(1 << `SB_REG_W) - 1];   // pending writer per register

    assign src1_fu     = rrs[dec_src1];
    assign src2_fu     = rrs[dec_src2];
    assign dst_pending = (dec_dst != '0) && (rrs[dec_dst] != `SB_FU_NONE);   // waw

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < (1 << `SB_REG_W); r++) begin
                rrs[r] <= `SB_FU_NONE;
            end
        end else begin
            if (wb_fu != `SB_FU_NONE) begin
                rrs[entry_dst[wb_fu]] <= `SB_FU_NONE;
            end
            // x0 never gets a writer
            if (record_en && dec_dst != '0) begin
                rrs[dec_dst] <= dec_fu;
            end
        end
    end

endmodule

// ==== logic/sb_consts.svh ====
`ifndef SB_CONSTS_SVH
`define SB_CONSTS_SVH

`define SB_XLEN   32
`define SB_REG_W  5
`define SB_FU_W   3
`define SB_OP_W   5
`define SB_NUM_FU 5

// unit codes, 0 = no unit
`define SB_FU_NONE 3'd0
`define SB_FU_ALU  3'd1
`define SB_FU_MEM  3'd2
`define SB_FU_MUL  3'd3
`define SB_FU_DIV  3'd4
`define SB_FU_JUMP 3'd5

// major opcodes
`define SB_OPC_OP     7'b0110011
`define SB_OPC_OP_IMM 7'b0010011
`define SB_OPC_LOAD   7'b0000011
`define SB_OPC_STORE  7'b0100011
`define SB_OPC_BRANCH 7'b1100011
`define SB_OPC_LUI    7'b0110111
`define SB_OPC_AUIPC  7'b0010111
`define SB_OPC_JAL    7'b1101111
`define SB_OPC_JALR   7'b1100111

`define SB_F7_BASE   7'h00
`define SB_F7_ALT    7'h20
`define SB_F7_MULDIV 7'h01

// operation code bases, funct3 is or-ed into the low bits
`define SB_OP_ADD   5'd0
`define SB_OP_ADDI  5'd16
`define SB_OP_LUI   5'd24
`define SB_OP_AUIPC 5'd25
`define SB_OP_LOAD  5'd0
`define SB_OP_STORE 5'd8
`define SB_OP_MUL   5'd0
`define SB_OP_DIV   5'd0
`define SB_OP_BEQ   5'd0
`define SB_OP_JAL   5'd8
`define SB_OP_JALR  5'd9

`endif

// ==== logic/sb_pkg.sv ====
`include "sb_consts.svh"

package sb_pkg;

    typedef logic [`SB_XLEN-1:0]  inst_word_t;
    typedef logic [`SB_REG_W-1:0] reg_idx_t;
    typedef logic [`SB_FU_W-1:0]  fu_id_t;   // 0 means no unit
    typedef logic [`SB_OP_W-1:0]  op_code_t;

    // issue side states around a jump
    typedef enum logic [1:0] {
        CTRL_RUN,
        CTRL_WAIT_JUMP,
        CTRL_FLUSH
    } ctrl_state_t;

endpackage

// ==== logic/scoreboard_ctrl.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module scoreboard_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  sb_pkg::inst_word_t inst,
    input  logic               alu_done,
    input  logic               mem_done,
    input  logic               mul_done,
    input  logic               div_done,
    input  logic               jump_done,
    input  logic               is_jump,
    output logic               issue_en,
    output logic               alu_en,
    output logic               mem_en,
    output logic               mul_en,
    output logic               div_en,
    output logic               jump_en,
    output sb_pkg::op_code_t   disp_op,
    output sb_pkg::reg_idx_t   rs1_ctrl,
    output sb_pkg::reg_idx_t   rs2_ctrl,
    output logic               reg_write,
    output sb_pkg::fu_id_t     write_sel,
    output sb_pkg::reg_idx_t   rd_ctrl
);
    import sb_pkg::*;

    // decode
    fu_id_t   dec_fu;
    op_code_t dec_op;
    reg_idx_t dec_dst;
    reg_idx_t dec_src1;
    reg_idx_t dec_src2;

    // issue
    fu_id_t src1_fu;
    fu_id_t src2_fu;
    logic   dst_pending;
    logic   record_en;

    // table state toward writeback
    logic     [`SB_NUM_FU:1] busy;
    reg_idx_t [`SB_NUM_FU:1] entry_src1;
    reg_idx_t [`SB_NUM_FU:1] entry_src2;
    logic     [`SB_NUM_FU:1] entry_rdy1;
    logic     [`SB_NUM_FU:1] entry_rdy2;
    reg_idx_t [`SB_NUM_FU:1] entry_dst;
    logic     [`SB_NUM_FU:1] entry_done;
    fu_id_t                  wb_fu;

    inst_decoder u_inst_decoder (.*);

    reg_result_status u_reg_result_status (.*);

    issue_control u_issue_control (.*);

    fu_status_table u_fu_status_table (.*);

    writeback_arbiter u_writeback_arbiter (.*);

endmodule

// ==== logic/writeback_arbiter.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module writeback_arbiter (
    input  sb_pkg::reg_idx_t [`SB_NUM_FU:1] entry_src1,
    input  sb_pkg::reg_idx_t [`SB_NUM_FU:1] entry_src2,
    input  logic [`SB_NUM_FU:1]             entry_rdy1,
    input  logic [`SB_NUM_FU:1]             entry_rdy2,
    input  sb_pkg::reg_idx_t [`SB_NUM_FU:1] entry_dst,
    input  logic [`SB_NUM_FU:1]             entry_done,
    output sb_pkg::fu_id_t                  wb_fu,
    output logic                            reg_write,
    output sb_pkg::fu_id_t                  write_sel,
    output sb_pkg::reg_idx_t                rd_ctrl
);
    import sb_pkg::*;

    logic [`SB_NUM_FU:1] war_ok;

    // blocked while another unit holds dst as a ready, unread source
    always_comb begin
        for (int u = 1; u <= `SB_NUM_FU; u++) begin
            war_ok[u] = 1'b1;
            for (int v = 1; v <= `SB_NUM_FU; v++) begin
                if (v != u && entry_dst[u] != '0 &&
                    ((entry_rdy1[v] && entry_src1[v] == entry_dst[u]) ||
                     (entry_rdy2[v] && entry_src2[v] == entry_dst[u]))) begin
                    war_ok[u] = 1'b0;
                end
            end
        end
    end

    // jump wins, then lowest code
    always_comb begin
        wb_fu = `SB_FU_NONE;
        for (int i = `SB_NUM_FU - 1; i >= 1; i--) begin
            if (entry_done[i] && war_ok[i]) begin
                wb_fu = fu_id_t'(i);
            end
        end
        if (entry_done[`SB_FU_JUMP] && war_ok[`SB_FU_JUMP]) begin
            wb_fu = `SB_FU_JUMP;
        end
    end

    assign reg_write = (wb_fu != `SB_FU_NONE);
    assign write_sel = wb_fu;
    assign rd_ctrl   = reg_write ? entry_dst[wb_fu] : '0;   // 0 for store/branch

endmodule

// ==== tb.f ====
+incdir+logic
logic/sb_pkg.sv
logic/inst_decoder.sv
logic/reg_result_status.sv
logic/issue_control.sv
logic/fu_status_table.sv
logic/writeback_arbiter.sv
logic/scoreboard_ctrl.sv
bench/scoreboard_ctrl_assertions.sv
bench/scoreboard_ctrl_tb.sv
